// File: hdl/clahe_macros.svh
// ======================================
// CLAHE tile memory sizes
// Tile grid, bins, bank layout and word widths
// ======================================
`ifndef CLAHE_MACROS_SVH
`define CLAHE_MACROS_SVH

// Tile grid of 4x4
`define CLAHE_TILE_X_BITS 2
`define CLAHE_TILE_Y_BITS 2

// 256 bins per tile
`define CLAHE_BIN_BITS 8

// Histogram counts and CDF entries
`define CLAHE_HIST_W 16
`define CLAHE_CDF_W 8

// Checkerboard banks, four tiles of 256 bins each
`define CLAHE_NUM_BANKS 4
`define CLAHE_BANK_AW 10
`define CLAHE_BANK_DEPTH 1024

`endif

// File: hdl/clahe_pkg.sv
// ======================================
// CLAHE tile memory types
// Word types and tile-to-bank decode
// ======================================
`default_nettype none
`include "clahe_macros.svh"

package clahe_pkg;

    // Tile index holds Y in the high half, X in the low half
    typedef logic [`CLAHE_TILE_Y_BITS+`CLAHE_TILE_X_BITS-1:0] tile_idx_t;
    typedef logic [`CLAHE_BIN_BITS-1:0]                       bin_addr_t;
    typedef logic [$clog2(`CLAHE_NUM_BANKS)-1:0]              bank_id_t;
    typedef logic [`CLAHE_BANK_AW-1:0]                        bank_addr_t;
    typedef logic [`CLAHE_HIST_W-1:0]                         hist_word_t;
    typedef logic [`CLAHE_CDF_W-1:0]                          cdf_word_t;

    // Position inside the 2x2 mapping window
    typedef enum logic [1:0] {
        WIN_TL = 2'd0,
        WIN_TR = 2'd1,
        WIN_BL = 2'd2,
        WIN_BR = 2'd3
    } win_pos_t;

    // One word per bank, indexed by bank id
    typedef hist_word_t [`CLAHE_NUM_BANKS-1:0] bank_words_t;

    // Bank id is {Y odd, X odd}
    function automatic bank_id_t bank_id_of(input tile_idx_t tile);
        logic [`CLAHE_TILE_X_BITS-1:0] tx;
        logic [`CLAHE_TILE_Y_BITS-1:0] ty;
        tx = tile[`CLAHE_TILE_X_BITS-1:0];
        ty = tile[`CLAHE_TILE_X_BITS +: `CLAHE_TILE_Y_BITS];
        return {ty[0], tx[0]};
    endfunction

    // Inner tile position inside the bank, then the bin
    function automatic bank_addr_t bank_addr_of(input tile_idx_t tile, input bin_addr_t bin);
        logic [`CLAHE_TILE_X_BITS-1:0] tx;
        logic [`CLAHE_TILE_Y_BITS-1:0] ty;
        tx = tile[`CLAHE_TILE_X_BITS-1:0];
        ty = tile[`CLAHE_TILE_X_BITS +: `CLAHE_TILE_Y_BITS];
        return {ty[`CLAHE_TILE_Y_BITS-1:1], tx[`CLAHE_TILE_X_BITS-1:1], bin};
    endfunction

endpackage

`default_nettype wire

// File: hdl/clahe_ifs.sv
// ======================================
// CLAHE bank port interfaces
// Single-address port A and parallel mapping port B
// ======================================
`timescale 1ns/10ps
`default_nettype none
`include "clahe_macros.svh"

// ======================================
// Port A: one shared address, per-bank write enables
// ======================================
interface bank_port_if;
    import clahe_pkg::*;

    logic [`CLAHE_NUM_BANKS-1:0] we;
    bank_addr_t                  addr;
    hist_word_t                  wdata;
    // Registered read word of every bank
    bank_words_t                 rdata;

    modport ctrl (output we, output addr, output wdata, input rdata);
    modport bank (input we, input addr, input wdata, output rdata);

endinterface

// ======================================
// Port B: independent read address per bank
// ======================================
interface map_port_if;
    import clahe_pkg::*;

    bank_addr_t  addr [`CLAHE_NUM_BANKS];
    bank_words_t rdata;

    modport xbar (output addr, input rdata);
    modport bank (input addr, output rdata);

endinterface

`default_nettype wire

// File: hdl/pingpong_ctrl.sv
// ======================================
// CLAHE ping-pong set controller
// Bulk clear, port-A arbitration, set routing
// and read-return selection
// ======================================
`timescale 1ns/10ps
`default_nettype none
`include "clahe_macros.svh"

module pingpong_ctrl (
    input  wire                        pclk,
    input  wire                        rst_n,
    input  wire                        ping_pong_flag_i,
    input  wire                        clear_start_i,
    output logic                       clear_done_o,
    input  wire clahe_pkg::tile_idx_t  hist_tile_i,
    input  wire clahe_pkg::bin_addr_t  hist_addr_i,
    input  wire                        hist_wr_en_i,
    input  wire clahe_pkg::hist_word_t hist_wr_data_i,
    input  wire clahe_pkg::tile_idx_t  cdf_tile_i,
    input  wire clahe_pkg::bin_addr_t  cdf_addr_i,
    input  wire                        cdf_wr_en_i,
    input  wire                        cdf_rd_en_i,
    input  wire clahe_pkg::cdf_word_t  cdf_wr_data_i,
    output clahe_pkg::hist_word_t      hist_rd_data_o,
    output clahe_pkg::hist_word_t      cdf_rd_data_o,
    bank_port_if.ctrl                  set0_a,
    bank_port_if.ctrl                  set1_a
);
    import clahe_pkg::*;

    logic                        clearing;
    bank_addr_t                  clear_cnt;
    bank_id_t                    hist_bank;
    bank_id_t                    cdf_bank;
    bank_id_t                    rd_bank;
    bank_addr_t                  hist_baddr;
    bank_addr_t                  cdf_baddr;
    logic [`CLAHE_NUM_BANKS-1:0] we;
    bank_addr_t                  a_addr;
    hist_word_t                  a_wdata;
    bank_id_t                    rd_bank_q;
    logic                        rd_set_q;
    hist_word_t                  rd_word;

    // ======================================
    // Bulk clear
    // ======================================
    // One address per cycle across all four banks at once
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            clearing  <= 1'b0;
            clear_cnt <= '0;
        end else if (clear_start_i) begin
            clearing  <= 1'b1;
            clear_cnt <= '0;
        end else if (clearing) begin
            if (clear_cnt == bank_addr_t'(`CLAHE_BANK_DEPTH - 1)) begin
                clearing <= 1'b0;
            end
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    assign clear_done_o = ~clearing;

    // Tile decode
    assign hist_bank  = bank_id_of(hist_tile_i);
    assign cdf_bank   = bank_id_of(cdf_tile_i);
    assign hist_baddr = bank_addr_of(hist_tile_i, hist_addr_i);
    assign cdf_baddr  = bank_addr_of(cdf_tile_i, cdf_addr_i);
    assign rd_bank    = cdf_rd_en_i ? cdf_bank : hist_bank;

    // ======================================
    // Port A arbitration
    // ======================================
    // Clear beats histogram write, which beats CDF write
    always_comb begin
        we      = '0;
        a_addr  = cdf_rd_en_i ? cdf_baddr : hist_baddr;
        a_wdata = hist_wr_data_i;
        if (clearing) begin
            we      = '1;
            a_addr  = clear_cnt;
            a_wdata = '0;
        end else if (hist_wr_en_i) begin
            for (int b = 0; b < `CLAHE_NUM_BANKS; b++) begin
                we[b] = (hist_bank == bank_id_t'(b));
            end
            a_addr = hist_baddr;
        end else if (cdf_wr_en_i) begin
            for (int b = 0; b < `CLAHE_NUM_BANKS; b++) begin
                we[b] = (cdf_bank == bank_id_t'(b));
            end
            a_addr  = cdf_baddr;
            a_wdata = {{(`CLAHE_HIST_W - `CLAHE_CDF_W){1'b0}}, cdf_wr_data_i};
        end
    end

    // Only the active set sees write enables
    assign set0_a.we    = ping_pong_flag_i ? '0 : we;
    assign set1_a.we    = ping_pong_flag_i ? we : '0;
    assign set0_a.addr  = a_addr;
    assign set1_a.addr  = a_addr;
    assign set0_a.wdata = a_wdata;
    assign set1_a.wdata = a_wdata;

    // ======================================
    // Read return
    // ======================================
    // Bank and set follow the registered read by one cycle
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bank_q <= '0;
            rd_set_q  <= 1'b0;
        end else begin
            rd_bank_q <= rd_bank;
            rd_set_q  <= ping_pong_flag_i;
        end
    end

    assign rd_word = rd_set_q ? set1_a.rdata[rd_bank_q] : set0_a.rdata[rd_bank_q];

    // Histogram and CDF reads share port A
    assign hist_rd_data_o = rd_word;
    assign cdf_rd_data_o  = rd_word;

endmodule

`default_nettype wire

// File: hdl/bank_set.sv
// ======================================
// CLAHE bank set
// Four checkerboard banks of one ping-pong set
// ======================================
`timescale 1ns/10ps
`default_nettype none
`include "clahe_macros.svh"

module bank_set (
    input  wire       pclk,
    bank_port_if.bank port_a,
    map_port_if.bank  port_b
);
    import clahe_pkg::*;

    // ======================================
    // Banks
    // ======================================
    for (genvar g = 0; g < `CLAHE_NUM_BANKS; g++) begin : g_bank
        hist_word_t mem [`CLAHE_BANK_DEPTH];
        hist_word_t rd_a_q;
        hist_word_t rd_b_q;

        // Port A write on this bank's own enable
        always_ff @(posedge pclk) begin
            if (port_a.we[g]) begin
                mem[port_a.addr] <= port_a.wdata;
            end
        end

        // Both ports read every cycle, old data on a same-address write
        always_ff @(posedge pclk) begin
            rd_a_q <= mem[port_a.addr];
            rd_b_q <= mem[port_b.addr[g]];
        end

        assign port_a.rdata[g] = rd_a_q;
        assign port_b.rdata[g] = rd_b_q;
    end

endmodule

`default_nettype wire

// File: hdl/mapping_xbar.sv
// ======================================
// CLAHE mapping crossbar
// Steers 2x2 window tiles onto banks and
// bank words back onto window positions
// ======================================
`timescale 1ns/10ps
`default_nettype none
`include "clahe_macros.svh"

module mapping_xbar (
    input  wire                       pclk,
    input  wire                       rst_n,
    input  wire                       ping_pong_flag_i,
    input  wire clahe_pkg::bin_addr_t map_addr_i,
    input  wire clahe_pkg::tile_idx_t map_tl_tile_i,
    input  wire clahe_pkg::tile_idx_t map_tr_tile_i,
    input  wire clahe_pkg::tile_idx_t map_bl_tile_i,
    input  wire clahe_pkg::tile_idx_t map_br_tile_i,
    output clahe_pkg::cdf_word_t      map_tl_data_o,
    output clahe_pkg::cdf_word_t      map_tr_data_o,
    output clahe_pkg::cdf_word_t      map_bl_data_o,
    output clahe_pkg::cdf_word_t      map_br_data_o,
    map_port_if.xbar                  set0_b,
    map_port_if.xbar                  set1_b
);
    import clahe_pkg::*;

    tile_idx_t   win_tile [4];
    bank_addr_t  bank_addr [`CLAHE_NUM_BANKS];
    bank_id_t    tl_bank_q;
    logic        map_set_q;
    bank_words_t raw;
    cdf_word_t   pos_word [4];

    assign win_tile[WIN_TL] = map_tl_tile_i;
    assign win_tile[WIN_TR] = map_tr_tile_i;
    assign win_tile[WIN_BL] = map_bl_tile_i;
    assign win_tile[WIN_BR] = map_br_tile_i;

    // ======================================
    // Address steering
    // ======================================
    // Each bank takes the window tile that lives in it, TL first
    always_comb begin
        for (int b = 0; b < `CLAHE_NUM_BANKS; b++) begin
            bank_addr[b] = bank_addr_of(win_tile[WIN_BR], map_addr_i);
            for (int p = 3; p >= 0; p--) begin
                if (bank_id_of(win_tile[p]) == bank_id_t'(b)) begin
                    bank_addr[b] = bank_addr_of(win_tile[p], map_addr_i);
                end
            end
        end
    end

    // Both sets get the same addresses, only one is picked on return
    assign set0_b.addr = bank_addr;
    assign set1_b.addr = bank_addr;

    // ======================================
    // Return crossbar
    // ======================================
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            tl_bank_q <= '0;
            map_set_q <= 1'b0;
        end else begin
            tl_bank_q <= bank_id_of(map_tl_tile_i);
            // Mapping set is the one not active
            map_set_q <= ~ping_pong_flag_i;
        end
    end

    assign raw = map_set_q ? set1_b.rdata : set0_b.rdata;

    // Window position XOR TL bank gives the bank holding that position
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            pos_word[p] = raw[bank_id_t'(p) ^ tl_bank_q][`CLAHE_CDF_W-1:0];
        end
    end

    assign map_tl_data_o = pos_word[WIN_TL];
    assign map_tr_data_o = pos_word[WIN_TR];
    assign map_bl_data_o = pos_word[WIN_BL];
    assign map_br_data_o = pos_word[WIN_BR];

endmodule

`default_nettype wire

// File: hdl/clahe_tile_store.sv
// ======================================
// CLAHE tile store
// Ping-pong histogram and CDF memory with
// a parallel 2x2 mapping read
// ======================================
`timescale 1ns/10ps
`default_nettype none

module clahe_tile_store (
    input  wire                        pclk,
    input  wire                        rst_n,
    input  wire                        ping_pong_flag_i,
    input  wire                        clear_start_i,
    output wire                        clear_done_o,
    // Histogram port
    input  wire clahe_pkg::tile_idx_t  hist_tile_i,
    input  wire clahe_pkg::bin_addr_t  hist_addr_i,
    input  wire                        hist_wr_en_i,
    input  wire clahe_pkg::hist_word_t hist_wr_data_i,
    output wire clahe_pkg::hist_word_t hist_rd_data_o,
    // CDF port
    input  wire clahe_pkg::tile_idx_t  cdf_tile_i,
    input  wire clahe_pkg::bin_addr_t  cdf_addr_i,
    input  wire                        cdf_wr_en_i,
    input  wire                        cdf_rd_en_i,
    input  wire clahe_pkg::cdf_word_t  cdf_wr_data_i,
    output wire clahe_pkg::hist_word_t cdf_rd_data_o,
    // Mapping port
    input  wire clahe_pkg::bin_addr_t  map_addr_i,
    input  wire clahe_pkg::tile_idx_t  map_tl_tile_i,
    input  wire clahe_pkg::tile_idx_t  map_tr_tile_i,
    input  wire clahe_pkg::tile_idx_t  map_bl_tile_i,
    input  wire clahe_pkg::tile_idx_t  map_br_tile_i,
    output wire clahe_pkg::cdf_word_t  map_tl_data_o,
    output wire clahe_pkg::cdf_word_t  map_tr_data_o,
    output wire clahe_pkg::cdf_word_t  map_bl_data_o,
    output wire clahe_pkg::cdf_word_t  map_br_data_o
);

    // Port A and port B of each set
    bank_port_if set0_a_if ();
    bank_port_if set1_a_if ();
    map_port_if  set0_b_if ();
    map_port_if  set1_b_if ();

    pingpong_ctrl u_ctrl (
        .pclk             (pclk),
        .rst_n            (rst_n),
        .ping_pong_flag_i (ping_pong_flag_i),
        .clear_start_i    (clear_start_i),
        .clear_done_o     (clear_done_o),
        .hist_tile_i      (hist_tile_i),
        .hist_addr_i      (hist_addr_i),
        .hist_wr_en_i     (hist_wr_en_i),
        .hist_wr_data_i   (hist_wr_data_i),
        .cdf_tile_i       (cdf_tile_i),
        .cdf_addr_i       (cdf_addr_i),
        .cdf_wr_en_i      (cdf_wr_en_i),
        .cdf_rd_en_i      (cdf_rd_en_i),
        .cdf_wr_data_i    (cdf_wr_data_i),
        .hist_rd_data_o   (hist_rd_data_o),
        .cdf_rd_data_o    (cdf_rd_data_o),
        .set0_a           (set0_a_if),
        .set1_a           (set1_a_if)
    );

    bank_set u_set0 (
        .pclk   (pclk),
        .port_a (set0_a_if),
        .port_b (set0_b_if)
    );

    bank_set u_set1 (
        .pclk   (pclk),
        .port_a (set1_a_if),
        .port_b (set1_b_if)
    );

    mapping_xbar u_xbar (
        .pclk             (pclk),
        .rst_n            (rst_n),
        .ping_pong_flag_i (ping_pong_flag_i),
        .map_addr_i       (map_addr_i),
        .map_tl_tile_i    (map_tl_tile_i),
        .map_tr_tile_i    (map_tr_tile_i),
        .map_bl_tile_i    (map_bl_tile_i),
        .map_br_tile_i    (map_br_tile_i),
        .map_tl_data_o    (map_tl_data_o),
        .map_tr_data_o    (map_tr_data_o),
        .map_bl_data_o    (map_bl_data_o),
        .map_br_data_o    (map_br_data_o),
        .set0_b           (set0_b_if),
        .set1_b           (set1_b_if)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clahe_tile_store.sv
// ======================================
// CLAHE tile store testbench
// Reference memory model with checks on every read port
// ======================================
`timescale 1ns/10ps
`default_nettype none
`include "clahe_macros.svh"

module tb_clahe_tile_store;
    import clahe_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TILES  = 1 << (`CLAHE_TILE_X_BITS + `CLAHE_TILE_Y_BITS);
    localparam int NUM_BINS   = 1 << `CLAHE_BIN_BITS;
    localparam int N_RAND     = 64;
    localparam int N_MAP_BINS = 4;
    // Reset, one clear, random accesses, CDF table, two window sweeps and a readback
    localparam int RUN_CYCLES = 16 + `CLAHE_BANK_DEPTH + 6 * N_RAND + 24
                              + NUM_TILES * N_MAP_BINS + 27 * N_MAP_BINS + 40;
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

    logic       pclk;
    logic       rst_n;
    logic       ping_pong_flag;
    logic       clear_start;
    wire        clear_done;
    tile_idx_t  hist_tile;
    bin_addr_t  hist_addr;
    logic       hist_wr_en;
    hist_word_t hist_wr_data;
    hist_word_t hist_rd_data;
    tile_idx_t  cdf_tile;
    bin_addr_t  cdf_addr;
    logic       cdf_wr_en;
    logic       cdf_rd_en;
    cdf_word_t  cdf_wr_data;
    hist_word_t cdf_rd_data;
    bin_addr_t  map_addr;
    tile_idx_t  map_tile [4];
    cdf_word_t  map_tl_data;
    cdf_word_t  map_tr_data;
    cdf_word_t  map_bl_data;
    cdf_word_t  map_br_data;

    // Two sets of 16 tiles by 256 bins
    hist_word_t  model [2][NUM_TILES][NUM_BINS];
    int          rd_due_q [$];
    logic        rd_cdf_q [$];
    hist_word_t  rd_exp_q [$];
    int          map_due_q [$];
    logic [31:0] map_exp_q [$];
    logic [31:0] lcg_state = 32'd63;
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    string       test_name;
    tile_idx_t   w_tile [N_RAND];
    bin_addr_t   w_bin [N_RAND];
    bin_addr_t   map_bins [N_MAP_BINS];

    clahe_tile_store uut (
        .pclk (pclk), .rst_n (rst_n), .ping_pong_flag_i (ping_pong_flag),
        .clear_start_i (clear_start), .clear_done_o (clear_done),
        .hist_tile_i (hist_tile), .hist_addr_i (hist_addr), .hist_wr_en_i (hist_wr_en),
        .hist_wr_data_i (hist_wr_data), .hist_rd_data_o (hist_rd_data),
        .cdf_tile_i (cdf_tile), .cdf_addr_i (cdf_addr), .cdf_wr_en_i (cdf_wr_en),
        .cdf_rd_en_i (cdf_rd_en), .cdf_wr_data_i (cdf_wr_data), .cdf_rd_data_o (cdf_rd_data),
        .map_addr_i (map_addr), .map_tl_tile_i (map_tile[0]), .map_tr_tile_i (map_tile[1]),
        .map_bl_tile_i (map_tile[2]), .map_br_tile_i (map_tile[3]),
        .map_tl_data_o (map_tl_data), .map_tr_data_o (map_tr_data),
        .map_bl_data_o (map_bl_data), .map_br_data_o (map_br_data)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    always @(posedge pclk) cyc <= cyc + 1;

    // ======================================
    // Reference model and random source
    // ======================================
    function automatic hist_word_t ref_word(input logic set, input tile_idx_t tile,
                                            input bin_addr_t bin);
        return model[set][tile][bin];
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic tile_idx_t rand_tile();
        return tile_idx_t'(next_rand() >> 28);
    endfunction

    function automatic bin_addr_t rand_bin();
        return bin_addr_t'(next_rand() >> 24);
    endfunction

    function automatic hist_word_t rand_hist();
        return hist_word_t'(next_rand() >> 16);
    endfunction

    function automatic cdf_word_t rand_cdf();
        return cdf_word_t'(next_rand() >> 24);
    endfunction

    function automatic tile_idx_t tile_at(input int x, input int y);
        return tile_idx_t'((y << `CLAHE_TILE_X_BITS) | x);
    endfunction

    // ======================================
    // Compare tasks and compare process
    // ======================================
    task automatic check_hist(input string what, input hist_word_t exp, input hist_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_map(input string what, input cdf_word_t exp, input cdf_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_cycles(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // Results fall due one cycle after their request
    always @(negedge pclk) begin : compare
        logic        is_cdf;
        hist_word_t  exp_word;
        logic [31:0] exp_map;
        while (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
            void'(rd_due_q.pop_front());
            is_cdf   = rd_cdf_q.pop_front();
            exp_word = rd_exp_q.pop_front();
            if (is_cdf) check_hist("cdf read", exp_word, cdf_rd_data);
            else check_hist("hist read", exp_word, hist_rd_data);
        end
        while (map_due_q.size() > 0 && map_due_q[0] <= cyc) begin
            void'(map_due_q.pop_front());
            exp_map = map_exp_q.pop_front();
            check_map("map TL", exp_map[31:24], map_tl_data);
            check_map("map TR", exp_map[23:16], map_tr_data);
            check_map("map BL", exp_map[15:8], map_bl_data);
            check_map("map BR", exp_map[7:0], map_br_data);
        end
    end

    // ======================================
    // Stimulus tasks, entered on a falling edge
    // ======================================
    task automatic idle();
        hist_wr_en  = 1'b0;
        cdf_wr_en   = 1'b0;
        cdf_rd_en   = 1'b0;
        clear_start = 1'b0;
    endtask

    task automatic expect_read(input logic is_cdf, input hist_word_t exp);
        rd_due_q.push_back(cyc + 1);
        rd_cdf_q.push_back(is_cdf);
        rd_exp_q.push_back(exp);
    endtask

    task automatic drive_hist_write(input tile_idx_t tile, input bin_addr_t bin,
                                    input hist_word_t data);
        idle();
        hist_wr_en   = 1'b1;
        hist_tile    = tile;
        hist_addr    = bin;
        hist_wr_data = data;
        model[ping_pong_flag][tile][bin] = data;
    endtask

    task automatic hist_write(input tile_idx_t tile, input bin_addr_t bin, input hist_word_t data);
        drive_hist_write(tile, bin, data);
        @(negedge pclk);
    endtask

    task automatic hist_read(input tile_idx_t tile, input bin_addr_t bin);
        idle();
        hist_tile = tile;
        hist_addr = bin;
        expect_read(1'b0, ref_word(ping_pong_flag, tile, bin));
        @(negedge pclk);
    endtask

    task automatic cdf_write(input tile_idx_t tile, input bin_addr_t bin, input cdf_word_t data);
        idle();
        cdf_wr_en   = 1'b1;
        cdf_tile    = tile;
        cdf_addr    = bin;
        cdf_wr_data = data;
        model[ping_pong_flag][tile][bin] = hist_word_t'(data);
        @(negedge pclk);
    endtask

    task automatic cdf_read(input tile_idx_t tile, input bin_addr_t bin);
        idle();
        cdf_rd_en = 1'b1;
        cdf_tile  = tile;
        cdf_addr  = bin;
        expect_read(1'b1, ref_word(ping_pong_flag, tile, bin));
        @(negedge pclk);
    endtask

    // Histogram write wins, so the CDF target keeps its old word
    task automatic write_collision(input tile_idx_t tile, input bin_addr_t bin,
                                   input hist_word_t hdata, input cdf_word_t cdata);
        drive_hist_write(tile, bin, hdata);
        cdf_wr_en   = 1'b1;
        cdf_tile    = tile ^ tile_idx_t'(5);
        cdf_addr    = bin;
        cdf_wr_data = cdata;
        @(negedge pclk);
    endtask

    // Window read from the set that is not active
    task automatic map_read(input int x, input int y, input bin_addr_t bin);
        logic ms;
        ms          = ~ping_pong_flag;
        map_tile[0] = tile_at(x, y);
        map_tile[1] = tile_at(x + 1, y);
        map_tile[2] = tile_at(x, y + 1);
        map_tile[3] = tile_at(x + 1, y + 1);
        map_addr    = bin;
        map_due_q.push_back(cyc + 1);
        map_exp_q.push_back({cdf_word_t'(ref_word(ms, map_tile[0], bin)),
                             cdf_word_t'(ref_word(ms, map_tile[1], bin)),
                             cdf_word_t'(ref_word(ms, map_tile[2], bin)),
                             cdf_word_t'(ref_word(ms, map_tile[3], bin))});
        @(negedge pclk);
    endtask

    task automatic run_clear();
        int low_cycles;
        clear_start = 1'b1;
        @(negedge pclk);
        clear_start = 1'b0;
        if (clear_done !== 1'b0) begin
            errors++;
            $display("clear_done_o did not fall in the cycle after clear_start_i");
        end
        low_cycles = 0;
        while (clear_done === 1'b0 && low_cycles < 2 * `CLAHE_BANK_DEPTH) begin
            low_cycles++;
            @(negedge pclk);
        end
        check_cycles("clear low time", `CLAHE_BANK_DEPTH, low_cycles);
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                model[ping_pong_flag][t][b] = '0;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        int guard;
        idle();
        guard = 0;
        while ((rd_due_q.size() > 0 || map_due_q.size() > 0) && guard < 8) begin
            guard++;
            @(negedge pclk);
        end
        if (rd_due_q.size() > 0 || map_due_q.size() > 0) begin
            errors++;
            $display("%s: read results were still pending at the end of the test", test_name);
        end
        $display("test %-14s %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    // ======================================
    // Test sequence
    // ======================================
    initial begin : stimulus
        tile_idx_t tile;
        bin_addr_t bin;
        int        n;
        rst_n          = 1'b0;
        ping_pong_flag = 1'b0;
        hist_tile      = '0;
        hist_addr      = '0;
        hist_wr_data   = '0;
        cdf_tile       = '0;
        cdf_addr       = '0;
        cdf_wr_data    = '0;
        map_addr       = '0;
        for (int p = 0; p < 4; p++) map_tile[p] = '0;
        idle();
        repeat (16) @(negedge pclk);
        rst_n = 1'b1;
        @(negedge pclk);

        start_test("clear_timing");
        if (clear_done !== 1'b1) begin
            errors++;
            $display("clear_done_o is not high after reset");
        end
        run_clear();
        end_test();

        start_test("clear_zero");
        for (int k = 0; k < N_RAND; k++) hist_read(rand_tile(), rand_bin());
        end_test();

        // Every tile gets the same share of writes
        start_test("hist_rw");
        for (int k = 0; k < N_RAND; k++) begin
            w_tile[k] = tile_idx_t'(k % NUM_TILES);
            w_bin[k]  = rand_bin();
            hist_write(w_tile[k], w_bin[k], rand_hist());
        end
        for (int k = 0; k < N_RAND; k++) hist_read(w_tile[k], w_bin[k]);
        end_test();

        start_test("cdf_rw");
        for (int k = 0; k < N_RAND / 2; k++) begin
            w_tile[k] = rand_tile();
            w_bin[k]  = rand_bin();
            cdf_write(w_tile[k], w_bin[k], rand_cdf());
        end
        for (int k = 0; k < N_RAND / 2; k++) cdf_read(w_tile[k], w_bin[k]);
        for (int k = 0; k < 8; k++) begin
            tile = rand_tile();
            bin  = rand_bin();
            write_collision(tile, bin, rand_hist(), rand_cdf());
            hist_read(tile, bin);
            cdf_read(tile ^ tile_idx_t'(5), bin);
        end
        end_test();

        // CDF table fills set 0, then set 0 becomes the mapping set
        start_test("map_window");
        for (int k = 0; k < N_MAP_BINS; k++) map_bins[k] = rand_bin();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int k = 0; k < N_MAP_BINS; k++) cdf_write(tile_idx_t'(t), map_bins[k], rand_cdf());
        end
        idle();
        ping_pong_flag = 1'b1;
        @(negedge pclk);
        for (int y = 0; y < 3; y++) begin
            for (int x = 0; x < 3; x++) begin
                for (int k = 0; k < N_MAP_BINS; k++) map_read(x, y, map_bins[k]);
            end
        end
        end_test();

        // Writes land in set 1 only, then are read back from set 1
        start_test("map_isolation");
        n = 0;
        for (int y = 0; y < 3; y++) begin
            for (int x = 0; x < 3; x++) begin
                for (int k = 0; k < N_MAP_BINS; k++) begin
                    w_tile[n] = rand_tile();
                    w_bin[n]  = map_bins[k];
                    drive_hist_write(w_tile[n], w_bin[n], rand_hist());
                    map_read(x, y, map_bins[k]);
                    n++;
                end
            end
        end
        for (int k = 0; k < n; k++) hist_read(w_tile[k], w_bin[k]);
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/clahe_pkg.sv
hdl/clahe_ifs.sv
hdl/pingpong_ctrl.sv
hdl/bank_set.sv
hdl/mapping_xbar.sv
hdl/clahe_tile_store.sv
testbench/tb_clahe_tile_store.sv

// File: Makefile
# Verilator build and run of the CLAHE tile store testbench

VERILATOR ?= verilator
TOP       ?= tb_clahe_tile_store
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing -j 0

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
